// File: lea.f
source/lea_pkg.sv
source/lea_round_key_ram.sv
source/lea_key_schedule.sv
source/lea_encrypt_core.sv
source/lea_top.sv
testbench/lea_tb.sv

// File: Makefile
# Verilator build for the LEA-128 encryption engine

TOP   = lea_tb
BUILD = obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f lea.f

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): lea.f source/*.sv testbench/*.sv
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -Mdir $(BUILD) -f lea.f

clean:
	rm -rf $(BUILD)

// File: testbench/lea_tb.sv
// LEA-128 engine testbench
// clock, reset, LFSR random source, behavioral LEA-128 model
// directed tests, cycle timeout and final report
`timescale 1ns/1ps

module lea_tb
    import lea_pkg::*;
();

    // tests need roughly 1100 cycles, limit leaves margin
    localparam int MAX_CYCLES = 2000;
    localparam int DONE_WAIT  = 80;
    localparam int KEY_WAIT   = 40;
    localparam logic [4:0] KS_ROT [4] = '{5'd1, 5'd3, 5'd6, 5'd11};

    logic   clk;
    logic   rst;
    key_t   key;
    logic   key_load;
    block_t block_in;
    logic   start;
    logic   key_ready;
    block_t block_out;
    logic   done;

    logic [31:0] lfsr_state;
    int          cycle_count = 0;

    lea_top u_lea_top (
        .clk       (clk),
        .rst       (rst),
        .key       (key),
        .key_load  (key_load),
        .block_in  (block_in),
        .start     (start),
        .key_ready (key_ready),
        .block_out (block_out),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_128(output logic [127:0] v);
        v = '0;
        for (int n = 0; n < 128; n++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[126:0], lfsr_state[0]};
        end
    endtask

    // behavioral LEA-128, key schedule and rounds interleaved
    function automatic block_t lea_model(input key_t k, input block_t pt);
        word_t t  [4];
        word_t x  [4];
        word_t rk [6];
        word_t x0_old;
        for (int j = 0; j < 4; j++) begin
            t[j] = order_word(k[127 - 32*j -: 32]);
            x[j] = order_word(pt[127 - 32*j -: 32]);
        end
        for (int i = 0; i < NUM_ROUNDS; i++) begin
            for (int j = 0; j < 4; j++) begin
                t[j] = rol32(t[j] + rol32(DELTA[i % 4], 5'(i + j)), KS_ROT[j]);
            end
            rk[0] = t[0];
            rk[1] = t[1];
            rk[2] = t[2];
            rk[3] = t[1];
            rk[4] = t[3];
            rk[5] = t[1];
            x0_old = x[0];
            x[0] = rol32((x[0] ^ rk[0]) + (x[1] ^ rk[1]), 5'd9);
            x[1] = ror32((x[1] ^ rk[2]) + (x[2] ^ rk[3]), 5'd5);
            x[2] = ror32((x[2] ^ rk[4]) + (x[3] ^ rk[5]), 5'd3);
            x[3] = x0_old;
        end
        return {order_word(x[0]), order_word(x[1]), order_word(x[2]), order_word(x[3])};
    endfunction

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic expect_bit(input string test, input logic exp, input logic act);
        assert (act === exp) else begin
            $display("Error: %s expected %0b actual %0b", test, exp, act);
            abort_run();
        end
    endtask

    task automatic expect_block(input string test, input block_t exp, input block_t act);
        assert (act === exp) else begin
            $display("Error: %s expected %h actual %h", test, exp, act);
            abort_run();
        end
    endtask

    task automatic load_key(input key_t k);
        int n;
        @(posedge clk);
        key      <= k;
        key_load <= 1'b1;
        @(posedge clk);
        key_load <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!key_ready && n < KEY_WAIT);
        assert (key_ready) else begin
            $display("key_ready did not rise within %0d cycles of key_load", KEY_WAIT);
            abort_run();
        end
    endtask

    task automatic encrypt(input block_t blk, output block_t result);
        int n;
        @(posedge clk);
        block_in <= blk;
        start    <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!done && n < DONE_WAIT);
        assert (done) else begin
            $display("done did not arrive within %0d cycles of start", DONE_WAIT);
            abort_run();
        end
        result = block_out;
    endtask

    task automatic reset_state_low();
        repeat (4) begin
            @(negedge clk);
            expect_bit("reset_state key_ready", 1'b0, key_ready);
            expect_bit("reset_state done", 1'b0, done);
            expect_block("reset_state block_out", '0, block_out);
        end
    endtask

    task automatic ignore_start_without_key();
        @(posedge clk);
        block_in <= 128'h00112233445566778899aabbccddeeff;
        start    <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        repeat (DONE_WAIT) begin
            @(negedge clk);
            expect_bit("start_without_key done", 1'b0, done);
        end
    endtask

    task automatic encrypt_single_block();
        key_t   k;
        block_t b;
        block_t result;
        k = 128'h0f1e2d3c4b5a69788796a5b4c3d2e1f0;
        b = 128'h101112131415161718191a1b1c1d1e1f;
        load_key(k);
        encrypt(b, result);
        expect_block("single_encryption", lea_model(k, b), result);
    endtask

    task automatic encrypt_random_pairs();
        key_t   k;
        block_t b;
        block_t result;
        for (int r = 0; r < 8; r++) begin
            random_128(k);
            random_128(b);
            load_key(k);
            encrypt(b, result);
            expect_block($sformatf("random_pair_%0d", r), lea_model(k, b), result);
        end
    endtask

    // returns the key left in the round-key RAM
    task automatic strobes_while_busy(output key_t k1);
        key_t   k2;
        block_t b1;
        block_t b2;
        block_t result;
        int     done_count;
        random_128(k1);
        random_128(k2);
        random_128(b1);
        random_128(b2);
        load_key(k1);
        @(posedge clk);
        block_in <= b1;
        start    <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        repeat (6) @(posedge clk);
        block_in <= b2;
        start    <= 1'b1;
        key      <= k2;
        key_load <= 1'b1;
        @(posedge clk);
        start    <= 1'b0;
        key_load <= 1'b0;
        done_count = 0;
        result     = '0;
        // long enough to see a wrongly accepted second start finish
        repeat (120) begin
            @(negedge clk);
            expect_bit("strobes_while_busy key_ready", 1'b1, key_ready);
            if (done) begin
                done_count++;
                result = block_out;
            end
        end
        assert (done_count == 1) else begin
            $display("Error: strobes_while_busy expected 1 done actual %0d", done_count);
            abort_run();
        end
        expect_block("strobes_while_busy", lea_model(k1, b1), result);
    endtask

    task automatic encrypt_back_to_back(input key_t k);
        block_t b;
        block_t result;
        for (int r = 0; r < 2; r++) begin
            random_128(b);
            encrypt(b, result);
            expect_block($sformatf("back_to_back_%0d", r), lea_model(k, b), result);
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == MAX_CYCLES) begin
            $display("timeout after %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    initial begin
        key_t held_key;
        rst        = 1'b1;
        key        = '0;
        key_load   = 1'b0;
        block_in   = '0;
        start      = 1'b0;
        lfsr_state = 32'd72471;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        reset_state_low();
        ignore_start_without_key();
        encrypt_single_block();
        encrypt_random_pairs();
        strobes_while_busy(held_key);
        encrypt_back_to_back(held_key);
        $display("all tests passed");
        $finish;
    end

endmodule

// File: source/lea_top.sv
// LEA-128 encryption engine top level
// key schedule, round-key RAM and encryption core
`timescale 1ns/1ps

module lea_top
    import lea_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  key_t   key,
    input  logic   key_load,
    input  block_t block_in,
    input  logic   start,
    output logic   key_ready,
    output block_t block_out,
    output logic   done
);

    // write side, owned by the key schedule
    logic       rk_we;
    rk_addr_t   rk_waddr;
    round_key_t rk_wdata;

    // read side, owned by the core
    rk_addr_t   rk_raddr;
    round_key_t rk_rdata;

    logic       busy;

    lea_key_schedule u_key_schedule (
        .clk       (clk),
        .rst       (rst),
        .key       (key),
        .key_load  (key_load),
        .busy      (busy),
        .rk_we     (rk_we),
        .rk_waddr  (rk_waddr),
        .rk_wdata  (rk_wdata),
        .key_ready (key_ready)
    );

    lea_round_key_ram #(
        .DEPTH (NUM_ROUNDS),
        .WIDTH ($bits(round_key_t))
    ) u_round_key_ram (
        .clk   (clk),
        .we    (rk_we),
        .waddr (rk_waddr),
        .wdata (rk_wdata),
        .raddr (rk_raddr),
        .rdata (rk_rdata)
    );

    lea_encrypt_core u_encrypt_core (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .block_in  (block_in),
        .key_ready (key_ready),
        .rk_raddr  (rk_raddr),
        .rk_rdata  (rk_rdata),
        .busy      (busy),
        .block_out (block_out),
        .done      (done)
    );

endmodule

// File: source/lea_encrypt_core.sv
// LEA-128 encryption core
// idle / fetch / round FSM, two cycles per round
// round keys read from the round-key RAM one per round
`timescale 1ns/1ps

module lea_encrypt_core
    import lea_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  block_t     block_in,
    input  logic       key_ready,
    output rk_addr_t   rk_raddr,
    input  round_key_t rk_rdata,
    output logic       busy,
    output block_t     block_out,
    output logic       done
);

    typedef enum logic [1:0] {
        CORE_IDLE,
        CORE_FETCH,
        CORE_ROUND
    } core_state_t;

    core_state_t state;
    rk_addr_t    rnd;
    word_t       x_q    [4];
    word_t       x_next [4];
    word_t       rk     [6];
    logic        start_ok;

    assign start_ok = start && key_ready && (state == CORE_IDLE);
    assign busy     = (state != CORE_IDLE);
    assign rk_raddr = rnd;

    // split the round key with RK0 in the top bits
    always_comb begin
        for (int k = 0; k < 6; k++) begin
            rk[k] = rk_rdata[191 - 32*k -: 32];
        end
    end

    // one LEA round
    always_comb begin
        x_next[0] = rol32((x_q[0] ^ rk[0]) + (x_q[1] ^ rk[1]), 5'd9);
        x_next[1] = ror32((x_q[1] ^ rk[2]) + (x_q[2] ^ rk[3]), 5'd5);
        x_next[2] = ror32((x_q[2] ^ rk[4]) + (x_q[3] ^ rk[5]), 5'd3);
        x_next[3] = x_q[0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= CORE_IDLE;
            rnd       <= '0;
            done      <= 1'b0;
            block_out <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                CORE_IDLE: begin
                    if (start_ok) begin
                        rnd   <= '0;
                        state <= CORE_FETCH;
                    end
                end
                // address goes out and the key comes back next cycle
                CORE_FETCH: begin
                    state <= CORE_ROUND;
                end
                CORE_ROUND: begin
                    if (rnd == rk_addr_t'(NUM_ROUNDS - 1)) begin
                        state     <= CORE_IDLE;
                        done      <= 1'b1;
                        block_out <= {order_word(x_next[0]), order_word(x_next[1]),
                                      order_word(x_next[2]), order_word(x_next[3])};
                    end else begin
                        rnd   <= rnd + rk_addr_t'(1);
                        state <= CORE_FETCH;
                    end
                end
                default: state <= CORE_IDLE;
            endcase
        end
    end

    // block state words
    always_ff @(posedge clk) begin
        if (start_ok) begin
            x_q[0] <= order_word(block_in[127:96]);
            x_q[1] <= order_word(block_in[95:64]);
            x_q[2] <= order_word(block_in[63:32]);
            x_q[3] <= order_word(block_in[31:0]);
        end else if (state == CORE_ROUND) begin
            for (int j = 0; j < 4; j++) begin
                x_q[j] <= x_next[j];
            end
        end
    end

endmodule

// File: source/lea_key_schedule.sv
// LEA-128 key schedule
// T-word registers updated once per cycle, one round key written per cycle
// key_ready level once all round keys are stored
`timescale 1ns/1ps

module lea_key_schedule
    import lea_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  key_t       key,
    input  logic       key_load,
    input  logic       busy,
    output logic       rk_we,
    output rk_addr_t   rk_waddr,
    output round_key_t rk_wdata,
    output logic       key_ready
);

    typedef enum logic {
        KS_IDLE,
        KS_EXPAND
    } ks_state_t;

    // per-word rotate amounts for 128-bit keys
    localparam logic [4:0] T_ROT [4] = '{5'd1, 5'd3, 5'd6, 5'd11};

    ks_state_t state;
    rk_addr_t  cnt;
    word_t     t_q    [4];
    word_t     t_next [4];
    logic      load_ok;

    // no new key while a block is in flight
    assign load_ok = key_load && !busy;

    // T[j] = rol(T[j] + rol(delta[i mod 4], i + j), rot[j])
    always_comb begin
        for (int j = 0; j < 4; j++) begin
            t_next[j] = rol32(t_q[j] + rol32(DELTA[{1'b0, cnt[1:0]}], cnt + rk_addr_t'(j)),
                              T_ROT[j]);
        end
    end

    assign rk_we    = (state == KS_EXPAND);
    assign rk_waddr = cnt;
    // RK = {T0, T1, T2, T1, T3, T1}
    assign rk_wdata = {t_next[0], t_next[1], t_next[2], t_next[1], t_next[3], t_next[1]};

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= KS_IDLE;
            cnt       <= '0;
            key_ready <= 1'b0;
        end else if (load_ok) begin
            state     <= KS_EXPAND;
            cnt       <= '0;
            key_ready <= 1'b0;
        end else if (state == KS_EXPAND) begin
            if (cnt == rk_addr_t'(NUM_ROUNDS - 1)) begin
                state     <= KS_IDLE;
                key_ready <= 1'b1;
            end else begin
                cnt <= cnt + rk_addr_t'(1);
            end
        end
    end

    // T words loaded from the reordered key
    always_ff @(posedge clk) begin
        if (load_ok) begin
            t_q[0] <= order_word(key[127:96]);
            t_q[1] <= order_word(key[95:64]);
            t_q[2] <= order_word(key[63:32]);
            t_q[3] <= order_word(key[31:0]);
        end else if (state == KS_EXPAND) begin
            for (int j = 0; j < 4; j++) begin
                t_q[j] <= t_next[j];
            end
        end
    end

endmodule

// File: source/lea_round_key_ram.sv
// round-key storage for the LEA engine
// simple dual-port RAM, synchronous write, registered read
`timescale 1ns/1ps

module lea_round_key_ram
    import lea_pkg::*;
#(
    parameter int DEPTH = NUM_ROUNDS,
    parameter int WIDTH = $bits(round_key_t)
) (
    input  logic       clk,
    input  logic       we,
    input  rk_addr_t   waddr,
    input  round_key_t wdata,
    input  rk_addr_t   raddr,
    output round_key_t rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        // one cycle read latency
        rdata <= mem[raddr];
    end

endmodule

// File: source/lea_pkg.sv
// LEA-128 shared definitions
// word, block, key and round-key types
// round count and key schedule delta constants
// byte-order and rotate helper functions
package lea_pkg;

    typedef logic [31:0]  word_t;
    typedef logic [127:0] block_t;
    typedef logic [127:0] key_t;
    // six words, RK0 in the top bits
    typedef logic [191:0] round_key_t;
    typedef logic [4:0]   rk_addr_t;

    localparam int NUM_ROUNDS = 24;

    // only the first four serve 128-bit keys
    localparam word_t DELTA [8] = '{
        32'hc3efe9db, 32'h44626b02, 32'h79e27c8a, 32'h78df30ec,
        32'h715ea49e, 32'hc785da0a, 32'he04ef22a, 32'he5c40957
    };

    // msb-first bytes to little-endian word and back
    function automatic word_t order_word(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic word_t rol32(input word_t x, input logic [4:0] amt);
        logic [5:0] back;
        back = 6'd32 - {1'b0, amt};
        return (x << amt) | (x >> back);
    endfunction

    function automatic word_t ror32(input word_t x, input logic [4:0] amt);
        logic [5:0] back;
        back = 6'd32 - {1'b0, amt};
        return (x >> amt) | (x << back);
    endfunction

endpackage
